//--- dv/tb_mips_pipeline.sv
// directed tests vs a sequential model; dmem is never cleared, so loads read earlier stores only
`timescale 1ns/1ps

module tb_mips_pipeline import cpu_pkg::*; ();

  logic       CLK = 1'b0;
  logic       nRST;
  logic       run;
  logic       prog_we;
  logic [5:0] prog_addr;
  word_t      prog_data;
  logic       wb_valid;
  reg_t       wb_sel;
  word_t      wb_data;
  logic       halt;

  word_t       prog[$];      // program under test
  reg_t        exp_sel[$];
  word_t       exp_data[$];
  reg_t        got_sel[$];
  word_t       got_data[$];
  word_t       model_rf [32];
  word_t       model_mem [DMEM_DEPTH];
  logic [15:0] lfsr = 16'd78;
  int          errors = 0;
  int          checks = 0;

  mips_pipeline u_dut (
    .CLK, .nRST, .run, .prog_we, .prog_addr, .prog_data,
    .wb_valid, .wb_sel, .wb_data, .halt
  );

  always #50 CLK = ~CLK;

  function automatic word_t rtype_word(logic [5:0] fn, reg_t rd, reg_t rs, reg_t rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t sll_word(reg_t rd, reg_t rt, logic [4:0] sh);
    return {OP_RTYPE, 5'd0, rt, rd, sh, FN_SLL};
  endfunction

  function automatic word_t itype_word(logic [5:0] op, reg_t rt, reg_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t halt_word();
    return {OP_HALT, 26'd0};
  endfunction

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // reference model running the program in order until halt
  task automatic interpret();
    word_t w;
    word_t a;
    word_t b;
    word_t sx;
    word_t ea;
    word_t val;
    reg_t  dst;
    logic  wr;
    exp_sel.delete();
    exp_data.delete();
    foreach (model_rf[i])
      model_rf[i] = '0;
    for (int pc = 0; pc < prog.size(); pc++) begin
      w = prog[pc];
      if (w[31:26] == OP_HALT)
        break;
      a   = model_rf[w[25:21]];
      b   = model_rf[w[20:16]];
      sx  = {{16{w[15]}}, w[15:0]};
      ea  = a + sx;
      dst = w[20:16];
      val = '0;
      wr  = 1'b1;
      case (w[31:26])
        OP_RTYPE: begin
          dst = w[15:11];
          case (w[5:0])
            FN_ADDU: val = a + b;
            FN_SUBU: val = a - b;
            FN_AND:  val = a & b;
            FN_OR:   val = a | b;
            FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLL:  val = b << w[10:6];
            default: wr = 1'b0;
          endcase
        end
        OP_ADDIU: val = a + sx;
        OP_ORI:   val = a | {16'h0000, w[15:0]};
        OP_LUI:   val = {w[15:0], 16'h0000};
        OP_LW:    val = model_mem[ea[7:2]];
        OP_SW: begin
          model_mem[ea[7:2]] = b;
          wr = 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != '0) begin // r0 writes leave no trace
        model_rf[dst] = val;
        exp_sel.push_back(dst);
        exp_data.push_back(val);
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge CLK);
    nRST    <= 1'b0;
    run     <= 1'b0;
    prog_we <= 1'b0;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  // writes the whole imem with halt padding after the program
  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(posedge CLK);
      prog_we   <= 1'b1;
      prog_addr <= 6'(i);
      prog_data <= (i < prog.size()) ? prog[i] : halt_word();
    end
    @(posedge CLK);
    prog_we <= 1'b0;
  endtask

  task automatic run_and_collect(string name);
    int cycles;
    got_sel.delete();
    got_data.delete();
    @(posedge CLK);
    run <= 1'b1;
    cycles = 0;
    do begin
      @(negedge CLK); // outputs settled
      if (wb_valid) begin
        got_sel.push_back(wb_sel);
        got_data.push_back(wb_data);
      end
      cycles++;
    end while (!halt && cycles < 400);
    checks++;
    assert (halt) else begin
      errors++;
      $display("%s: timed out waiting for halt after %0d cycles", name, cycles);
    end
    if (halt) begin
      repeat (8) begin // drained core must stay quiet
        @(negedge CLK);
        checks++;
        assert (!wb_valid && halt) else begin
          errors++;
          $display("%s: register write or halt drop seen after halt", name);
        end
      end
    end
  endtask

  task automatic compare_trace(string name);
    checks++;
    assert (got_sel.size() == exp_sel.size()) else begin
      errors++;
      $display("%s: trace has %0d register writes but %0d were expected",
               name, got_sel.size(), exp_sel.size());
    end
    for (int i = 0; i < got_sel.size() && i < exp_sel.size(); i++) begin
      checks += 2;
      assert (got_sel[i] === exp_sel[i]) else begin
        errors++;
        $display("Fail %s wb_sel entry %0d: got 0x%h, expected 0x%h",
                 name, i, got_sel[i], exp_sel[i]);
      end
      assert (got_data[i] === exp_data[i]) else begin
        errors++;
        $display("Fail %s wb_data entry %0d: got 0x%h, expected 0x%h",
                 name, i, got_data[i], exp_data[i]);
      end
    end
  endtask

  task automatic run_and_compare(string name);
    apply_reset();
    load_program();
    interpret();
    run_and_collect(name);
    compare_trace(name);
  endtask

  task automatic r_type_arith();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'hfff9)); // r1 = -7
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'd12));
    prog.push_back(rtype_word(FN_ADDU, 4, 1, 2));
    prog.push_back(rtype_word(FN_SUBU, 5, 1, 2));
    prog.push_back(rtype_word(FN_SUBU, 6, 2, 1));
    prog.push_back(rtype_word(FN_AND, 7, 1, 2));
    prog.push_back(rtype_word(FN_OR, 8, 1, 2));
    prog.push_back(rtype_word(FN_SLT, 9, 1, 2));  // negative < positive
    prog.push_back(rtype_word(FN_SLT, 10, 2, 1));
    prog.push_back(sll_word(11, 2, 5'd4));
    prog.push_back(sll_word(12, 1, 5'd31));
    prog.push_back(halt_word());
    run_and_compare("rtype");
  endtask

  task automatic immediate_ops();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'h8001));
    prog.push_back(itype_word(OP_ORI, 2, 0, 16'h8001)); // zero extended
    prog.push_back(itype_word(OP_LUI, 3, 0, 16'habcd));
    prog.push_back(itype_word(OP_ORI, 3, 3, 16'h1234));
    prog.push_back(itype_word(OP_ADDIU, 0, 0, 16'h0055));
    prog.push_back(itype_word(OP_ORI, 0, 3, 16'hffff));
    prog.push_back(rtype_word(FN_ADDU, 4, 0, 3));
    prog.push_back(rtype_word(FN_OR, 5, 0, 0));
    prog.push_back(itype_word(OP_ADDIU, 6, 1, 16'hffff));
    prog.push_back(halt_word());
    run_and_compare("immediate");
  endtask

  task automatic forward_distances();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'd3));
    prog.push_back(itype_word(OP_ADDIU, 1, 1, 16'd4)); // distance 1
    prog.push_back(sll_word(2, 1, 5'd2));
    prog.push_back(rtype_word(FN_ADDU, 3, 1, 2));     // distance 2 and 1
    prog.push_back(rtype_word(FN_SUBU, 4, 1, 3));     // distance 3 and 1
    prog.push_back(rtype_word(FN_AND, 5, 2, 2));
    prog.push_back(rtype_word(FN_OR, 6, 3, 4));
    prog.push_back(rtype_word(FN_SLT, 7, 4, 6));
    prog.push_back(itype_word(OP_ADDIU, 8, 7, 16'h0100));
    prog.push_back(itype_word(OP_ADDIU, 10, 0, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 10, 0, 16'd2));
    prog.push_back(rtype_word(FN_ADDU, 11, 10, 10)); // newest r10 wins
    prog.push_back(halt_word());
    run_and_compare("forward");
  endtask

  task automatic load_store();
    prog.delete();
    prog.push_back(itype_word(OP_LUI, 1, 0, 16'hdead));
    prog.push_back(itype_word(OP_ORI, 1, 1, 16'hbeef));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'hfffe));
    prog.push_back(itype_word(OP_SW, 1, 0, 16'd0));
    prog.push_back(itype_word(OP_SW, 2, 0, 16'd4));
    prog.push_back(itype_word(OP_ADDIU, 7, 0, 16'h0040));
    prog.push_back(itype_word(OP_SW, 7, 7, 16'd8));   // base and data forwarded
    prog.push_back(itype_word(OP_LW, 3, 0, 16'd0));
    prog.push_back(itype_word(OP_LW, 4, 0, 16'd4));
    prog.push_back(rtype_word(FN_ADDU, 5, 4, 3));     // load-use on rs
    prog.push_back(itype_word(OP_LW, 6, 7, 16'd8));
    prog.push_back(rtype_word(FN_SUBU, 8, 1, 6));     // load-use on rt
    prog.push_back(itype_word(OP_LW, 9, 0, 16'd0));
    prog.push_back(itype_word(OP_SW, 9, 0, 16'd12));  // loaded word stored at once
    prog.push_back(itype_word(OP_LW, 10, 0, 16'd12));
    prog.push_back(itype_word(OP_ADDIU, 10, 10, 16'd1));
    prog.push_back(halt_word());
    run_and_compare("memory");
  endtask

  task automatic halt_drain();
    prog.delete();
    prog.push_back(itype_word(OP_ADDIU, 1, 0, 16'd1));
    prog.push_back(itype_word(OP_ADDIU, 2, 0, 16'd2));
    prog.push_back(rtype_word(FN_ADDU, 3, 1, 2));
    prog.push_back(halt_word());
    prog.push_back(itype_word(OP_ADDIU, 4, 0, 16'd4)); // never retires
    prog.push_back(itype_word(OP_ADDIU, 5, 0, 16'd5));
    prog.push_back(itype_word(OP_ORI, 1, 0, 16'h0077));
    run_and_compare("halt");
  endtask

  task automatic random_alu_program();
    int          sel;
    reg_t        rd;
    reg_t        rs;
    reg_t        rt;
    logic [15:0] imm;
    prog.delete();
    for (int i = 0; i < 40; i++) begin
      sel = rand_bits(4) % 9;
      rd  = reg_t'(rand_bits(5));
      rs  = reg_t'(rand_bits(5));
      rt  = reg_t'(rand_bits(5));
      imm = 16'(rand_bits(16));
      case (sel)
        0: prog.push_back(rtype_word(FN_ADDU, rd, rs, rt));
        1: prog.push_back(rtype_word(FN_SUBU, rd, rs, rt));
        2: prog.push_back(rtype_word(FN_AND, rd, rs, rt));
        3: prog.push_back(rtype_word(FN_OR, rd, rs, rt));
        4: prog.push_back(rtype_word(FN_SLT, rd, rs, rt));
        5: prog.push_back(sll_word(rd, rt, 5'(rand_bits(5))));
        6: prog.push_back(itype_word(OP_ADDIU, rt, rs, imm));
        7: prog.push_back(itype_word(OP_ORI, rt, rs, imm));
        default: prog.push_back(itype_word(OP_LUI, rt, 0, imm));
      endcase
    end
    prog.push_back(halt_word());
    run_and_compare("random");
  endtask

  initial begin
    nRST      <= 1'b0;
    run       <= 1'b0;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    foreach (model_mem[i])
      model_mem[i] = '0;
    r_type_arith();
    immediate_ops();
    forward_distances();
    load_store();
    halt_drain();
    random_alu_program();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- mips_pipeline.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/pipe_reg.sv
src/decode_unit.sv
src/register_file.sv
src/hazard_forward.sv
src/execute_unit.sv
src/data_memory.sv
src/mips_pipeline.sv
dv/tb_mips_pipeline.sv

//--- src/cpu_pkg.sv
// shared types and encodings for the reduced mips core; no branches, no traps, memories are 64 words
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL
  } aluop_t;

  localparam int IMEM_DEPTH = 64; // instruction words
  localparam int DMEM_DEPTH = 64; // data words

  // opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_HALT  = 6'h3f;

  // r-type funct codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  // alu operand b source
  localparam logic [1:0] SRC_REG   = 2'd0;
  localparam logic [1:0] SRC_IMM   = 2'd1;
  localparam logic [1:0] SRC_LUI   = 2'd2; // imm in upper half
  localparam logic [1:0] SRC_SHAMT = 2'd3;

  // forwarding source for an execute operand
  localparam logic [1:0] FWD_REG = 2'd0; // value read in decode
  localparam logic [1:0] FWD_MEM = 2'd1; // ex/mem alu result
  localparam logic [1:0] FWD_WB  = 2'd2; // mem/wb write data

  typedef struct packed {
    word_t instr;
    logic  valid;
  } ifid_t;

  typedef struct packed {
    aluop_t     alu_op;
    logic [1:0] alu_src;
    logic       reg_dst;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    word_t      rdat1;
    word_t      rdat2;
    word_t      imm;
    logic [4:0] shamt;
    reg_t       rs;
    reg_t       rt;
    reg_t       rd;
    logic       halt;
  } idex_t;

  typedef struct packed {
    word_t result;
    word_t store_data;
    reg_t  dest;
    logic  reg_write;
    logic  mem_read;
    logic  mem_write;
    logic  halt;
  } exmem_t;

  typedef struct packed {
    word_t wdata;
    reg_t  dest;
    logic  reg_write;
    logic  halt;
  } memwb_t;

endpackage

//--- src/data_memory.sv
// 64 words selected by byte address bits 7..2, upper bits ignored; contents start undefined
`timescale 1ns/1ps

module data_memory import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t addr,
  input  logic  wen,
  input  word_t wdat,
  output word_t rdat
);

  word_t      mem [DMEM_DEPTH];
  logic [5:0] widx;

  assign widx = addr[7:2];
  assign rdat = mem[widx]; // combinational read

  always_ff @(posedge CLK) begin
    if (wen)
      mem[widx] <= wdat;
  end

  // stores come from sw with a computed address
  a_store_aligned: assert property (
    @(posedge CLK) disable iff (!nRST) wen |-> addr[1:0] == 2'b00
  );

endmodule

//--- src/decode_unit.sv
// unknown opcodes and functs decode as no-ops; lui and sll remap rs so operand a is right
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
  input  word_t      instr,
  input  logic       instr_valid,
  output aluop_t     alu_op,
  output logic [1:0] alu_src,
  output logic       reg_dst,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write,
  output logic       is_halt,
  output word_t      imm,
  output logic [4:0] shamt,
  output reg_t       rs,
  output reg_t       rt,
  output reg_t       rd
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];

  always_comb begin
    alu_op    = ALU_ADD;
    alu_src   = SRC_REG;
    reg_dst   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_halt   = 1'b0;
    rs        = instr[25:21];
    imm       = {{16{instr[15]}}, instr[15:0]}; // sign extended by default

    if (instr_valid) begin
      case (opcode)
        OP_RTYPE: begin
          reg_dst   = 1'b1;
          reg_write = 1'b1;
          case (funct)
            FN_ADDU: alu_op = ALU_ADD;
            FN_SUBU: alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_SLT:  alu_op = ALU_SLT;
            FN_SLL: begin
              alu_op  = ALU_SLL;
              alu_src = SRC_SHAMT;
              rs      = instr[20:16]; // shifted value is rt, fed as operand a
            end
            default: reg_write = 1'b0;
          endcase
        end
        OP_ADDIU: begin
          alu_src   = SRC_IMM;
          reg_write = 1'b1;
        end
        OP_ORI: begin
          alu_op    = ALU_OR;
          alu_src   = SRC_IMM;
          reg_write = 1'b1;
          imm       = {16'h0000, instr[15:0]};
        end
        OP_LUI: begin
          alu_src   = SRC_LUI;
          reg_write = 1'b1;
          rs        = '0; // 0 + upper imm
        end
        OP_LW: begin
          alu_src   = SRC_IMM;
          reg_write = 1'b1;
          mem_read  = 1'b1;
        end
        OP_SW: begin
          alu_src   = SRC_IMM;
          mem_write = 1'b1;
        end
        OP_HALT: is_halt = 1'b1;
        default: ; // no-op
      endcase
    end
  end

endmodule

//--- src/execute_unit.sv
// operand a is always a register; slt is signed, sll shifts by shamt only
`timescale 1ns/1ps

module execute_unit import cpu_pkg::*; (
  input  aluop_t     alu_op,
  input  logic [1:0] alu_src,
  input  logic       reg_dst,
  input  word_t      rdat1,
  input  word_t      rdat2,
  input  word_t      imm,
  input  logic [4:0] shamt,
  input  reg_t       rt,
  input  reg_t       rd,
  input  logic [1:0] fwd_a,
  input  logic [1:0] fwd_b,
  input  word_t      mem_result,
  input  word_t      wb_result,
  output word_t      result,
  output word_t      store_data,
  output reg_t       dest
);

  word_t op_a;
  word_t op_b_reg; // forwarded rt value
  word_t op_b;

  function automatic word_t fwd_mux(input logic [1:0] sel, input word_t rf_val,
                                    input word_t mem_val, input word_t wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  assign op_a     = fwd_mux(fwd_a, rdat1, mem_result, wb_result);
  assign op_b_reg = fwd_mux(fwd_b, rdat2, mem_result, wb_result);

  always_comb begin
    case (alu_src)
      SRC_IMM:   op_b = imm;
      SRC_LUI:   op_b = {imm[15:0], 16'h0000};
      SRC_SHAMT: op_b = {27'd0, shamt};
      default:   op_b = op_b_reg;
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR:  result = op_a | op_b;
      ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLL: result = op_a << op_b[4:0];
      default: result = op_a + op_b; // add and address calc
    endcase
  end

  assign store_data = op_b_reg;
  assign dest       = reg_dst ? rd : rt; // r-type writes rd

endmodule

//--- src/fetch_unit.sv
// pc counts words from 0 and wraps at 64; program load is ignored while run is high
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       run,
  input  logic       stall,
  input  logic       halt_seen,
  input  logic       prog_we,
  input  logic [5:0] prog_addr,
  input  word_t      prog_data,
  output word_t      instr,
  output logic       instr_valid
);

  word_t      imem [IMEM_DEPTH];
  logic [5:0] pc;
  logic       halted;  // set once decode has seen halt
  logic       advance;

  // decode halt stops the very next fetch, the flag keeps it stopped
  assign advance     = run && !stall && !halt_seen && !halted;
  assign instr       = imem[pc];
  assign instr_valid = advance;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc     <= '0;
      halted <= 1'b0;
    end else begin
      if (halt_seen)
        halted <= 1'b1;
      if (advance)
        pc <= pc + 6'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (prog_we && !run)
      imem[prog_addr] <= prog_data; // loader strobe
  end

  // loading a running program would corrupt fetch
  a_no_load_while_run: assert property (
    @(posedge CLK) disable iff (!nRST) !(prog_we && run)
  );

endmodule

//--- src/hazard_forward.sv
// loads always target rt, so the load-use check looks at the id/ex rt only
`timescale 1ns/1ps

module hazard_forward import cpu_pkg::*; (
  input  reg_t       ex_rs,
  input  reg_t       ex_rt,
  input  logic       ex_mem_read,
  input  reg_t       id_rs,
  input  reg_t       id_rt,
  input  reg_t       mem_rd,
  input  logic       mem_reg_write,
  input  reg_t       wb_rd,
  input  logic       wb_reg_write,
  output logic [1:0] fwd_a,
  output logic [1:0] fwd_b,
  output logic       stall
);

  logic mem_live; // ex/mem will write a real register
  logic wb_live;

  assign mem_live = mem_reg_write && mem_rd != '0;
  assign wb_live  = wb_reg_write && wb_rd != '0;

  // nearest producer wins
  function automatic logic [1:0] pick_src(input reg_t src, input logic m_live,
                                          input reg_t m_rd, input logic w_live, input reg_t w_rd);
    if (m_live && m_rd == src)
      return FWD_MEM;
    else if (w_live && w_rd == src)
      return FWD_WB;
    else
      return FWD_REG;
  endfunction

  assign fwd_a = pick_src(ex_rs, mem_live, mem_rd, wb_live, wb_rd);
  assign fwd_b = pick_src(ex_rt, mem_live, mem_rd, wb_live, wb_rd);

  // hold decode one cycle while the load is in execute
  assign stall = ex_mem_read && ex_rt != '0 && (ex_rt == id_rs || ex_rt == id_rt);

endmodule

//--- src/mips_pipeline.sv
// five-stage core with no branches; hold run high until halt, load the program while run is low
`timescale 1ns/1ps

module mips_pipeline import cpu_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  input  logic       run,
  input  logic       prog_we,
  input  logic [5:0] prog_addr,
  input  word_t      prog_data,
  output logic       wb_valid,
  output reg_t       wb_sel,
  output word_t      wb_data,
  output logic       halt
);

  ifid_t  ifid_d, ifid_q;
  idex_t  idex_d, idex_q;
  exmem_t exmem_d, exmem_q;
  memwb_t memwb_d, memwb_q;

  word_t      f_instr;
  logic       f_valid;
  aluop_t     d_alu_op;
  logic [1:0] d_alu_src;
  logic       d_reg_dst, d_reg_write, d_mem_read, d_mem_write, d_is_halt;
  word_t      d_imm;
  logic [4:0] d_shamt;
  reg_t       d_rs, d_rt, d_rd;
  word_t      rf_rdat1, rf_rdat2;
  logic [1:0] fwd_a, fwd_b;
  logic       stall;
  word_t      ex_result, ex_store;
  reg_t       ex_dest;
  word_t      dmem_rdat;
  logic       halt_q;  // sticky

  fetch_unit u_fetch (
    .CLK, .nRST, .run, .stall, .halt_seen(d_is_halt),
    .prog_we, .prog_addr, .prog_data,
    .instr(f_instr), .instr_valid(f_valid)
  );

  assign ifid_d = '{instr: f_instr, valid: f_valid};

  pipe_reg #(.PAYLOAD_T(ifid_t)) u_ifid (
    .CLK, .nRST, .en(!stall), .bubble(1'b0), .d(ifid_d), .q(ifid_q)
  );

  decode_unit u_decode (
    .instr(ifid_q.instr), .instr_valid(ifid_q.valid),
    .alu_op(d_alu_op), .alu_src(d_alu_src), .reg_dst(d_reg_dst),
    .reg_write(d_reg_write), .mem_read(d_mem_read), .mem_write(d_mem_write),
    .is_halt(d_is_halt), .imm(d_imm), .shamt(d_shamt),
    .rs(d_rs), .rt(d_rt), .rd(d_rd)
  );

  register_file u_rf (
    .CLK, .nRST, .rsel1(d_rs), .rsel2(d_rt), .rdat1(rf_rdat1), .rdat2(rf_rdat2),
    .wen(memwb_q.reg_write), .wsel(memwb_q.dest), .wdat(memwb_q.wdata)
  );

  assign idex_d = '{alu_op: d_alu_op, alu_src: d_alu_src, reg_dst: d_reg_dst,
                    reg_write: d_reg_write, mem_read: d_mem_read,
                    mem_write: d_mem_write, rdat1: rf_rdat1, rdat2: rf_rdat2,
                    imm: d_imm, shamt: d_shamt, rs: d_rs, rt: d_rt, rd: d_rd,
                    halt: d_is_halt};

  // stall drops a bubble into execute
  pipe_reg #(.PAYLOAD_T(idex_t)) u_idex (
    .CLK, .nRST, .en(1'b1), .bubble(stall), .d(idex_d), .q(idex_q)
  );

  hazard_forward u_hazard (
    .ex_rs(idex_q.rs), .ex_rt(idex_q.rt), .ex_mem_read(idex_q.mem_read),
    .id_rs(d_rs), .id_rt(d_rt),
    .mem_rd(exmem_q.dest), .mem_reg_write(exmem_q.reg_write),
    .wb_rd(memwb_q.dest), .wb_reg_write(memwb_q.reg_write),
    .fwd_a, .fwd_b, .stall
  );

  execute_unit u_execute (
    .alu_op(idex_q.alu_op), .alu_src(idex_q.alu_src), .reg_dst(idex_q.reg_dst),
    .rdat1(idex_q.rdat1), .rdat2(idex_q.rdat2), .imm(idex_q.imm),
    .shamt(idex_q.shamt), .rt(idex_q.rt), .rd(idex_q.rd),
    .fwd_a, .fwd_b, .mem_result(exmem_q.result), .wb_result(memwb_q.wdata),
    .result(ex_result), .store_data(ex_store), .dest(ex_dest)
  );

  assign exmem_d = '{result: ex_result, store_data: ex_store, dest: ex_dest,
                     reg_write: idex_q.reg_write, mem_read: idex_q.mem_read,
                     mem_write: idex_q.mem_write, halt: idex_q.halt};

  pipe_reg #(.PAYLOAD_T(exmem_t)) u_exmem (
    .CLK, .nRST, .en(1'b1), .bubble(1'b0), .d(exmem_d), .q(exmem_q)
  );

  data_memory u_dmem (
    .CLK, .nRST, .addr(exmem_q.result), .wen(exmem_q.mem_write),
    .wdat(exmem_q.store_data), .rdat(dmem_rdat)
  );

  assign memwb_d = '{wdata: exmem_q.mem_read ? dmem_rdat : exmem_q.result, // load or alu
                     dest: exmem_q.dest, reg_write: exmem_q.reg_write,
                     halt: exmem_q.halt};

  pipe_reg #(.PAYLOAD_T(memwb_t)) u_memwb (
    .CLK, .nRST, .en(1'b1), .bubble(1'b0), .d(memwb_d), .q(memwb_q)
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      halt_q <= 1'b0;
    else if (memwb_q.halt)
      halt_q <= 1'b1;
  end

  // trace of every real register write
  assign wb_valid = memwb_q.reg_write && memwb_q.dest != '0;
  assign wb_sel   = memwb_q.dest;
  assign wb_data  = memwb_q.wdata;
  assign halt     = halt_q || memwb_q.halt; // high from the halt wb cycle on

  // the drain after halt must leave nothing behind it
  a_no_wb_after_halt: assert property (
    @(posedge CLK) disable iff (!nRST) halt_q |-> !wb_valid
  );

endmodule

//--- src/pipe_reg.sv
// stage latch for any packed payload; bubble wins over enable and loads all zeros
`timescale 1ns/1ps

module pipe_reg #(
  parameter type PAYLOAD_T = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     en,
  input  logic     bubble,
  input  PAYLOAD_T d,
  output PAYLOAD_T q
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (bubble) begin
      q <= '0;    // all control bits clear
    end else if (en) begin
      q <= d;
    end
    // otherwise hold
  end

endmodule

//--- src/register_file.sv
// 32 registers, r0 always reads zero; a write in this cycle is seen by both reads
`timescale 1ns/1ps

module register_file import cpu_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  reg_t  rsel1,
  input  reg_t  rsel2,
  output word_t rdat1,
  output word_t rdat2,
  input  logic  wen,
  input  reg_t  wsel,
  input  word_t wdat
);

  word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && wsel != '0) begin
      regs[wsel] <= wdat;
    end
  end

  // write-first bypass
  always_comb begin
    if (rsel1 == '0)                  rdat1 = '0;
    else if (wen && wsel == rsel1)    rdat1 = wdat;
    else                              rdat1 = regs[rsel1];

    if (rsel2 == '0)                  rdat2 = '0;
    else if (wen && wsel == rsel2)    rdat2 = wdat;
    else                              rdat2 = regs[rsel2];
  end

endmodule
